//--- Makefile
# Verilator flow for the white balance stage.

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= wb_tb
RTL_TOP    ?= wb_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

ALL_SRCS := $(shell cat $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(ALL_SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The binary exits non-zero on $fatal, which fails this target.
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
verilog/wb_pkg.sv
verilog/video_if.sv
verilog/stats_if.sv
verilog/wb_stats_accum.sv
verilog/wb_divider.sv
verilog/wb_ctrl.sv
verilog/wb_pixel_gain.sv
verilog/wb_top.sv
verification/wb_tb.sv

//--- verification/wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module wb_tb import wb_pkg::*; ();

    localparam int CLK_PERIOD      = 10;
    localparam int FRAME_W         = 16;
    localparam int FRAME_H         = 8;
    localparam int HSYNC_LEN       = 2;
    localparam int H_PORCH         = 2;
    localparam int LINE_CYCLES     = HSYNC_LEN + 2 * H_PORCH + FRAME_W;
    localparam int V_PRE           = 4;
    localparam int VSYNC_LEN       = 4;
    localparam int V_BLANK         = 200;    // Covers the three divisions.
    localparam int FRAME_CYCLES    = FRAME_H * LINE_CYCLES + V_PRE + VSYNC_LEN + V_BLANK;
    localparam int NUM_FRAMES      = 13;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 1000;
    localparam int PIPE_DEPTH      = 2;

    // Pixel sources for a frame.
    localparam int SRC_RANDOM  = 0;
    localparam int SRC_GRAY    = 1;
    localparam int SRC_FIXED   = 2;
    localparam int SRC_NO_BLUE = 3;

    logic clk;
    logic i_arst_n;
    logic wb_en;
    logic vsync;
    logic hsync;
    logic de;
    pix_t r;
    pix_t g;
    pix_t b;
    logic o_vsync;
    logic o_hsync;
    logic o_de;
    pix_t o_r;
    pix_t o_g;
    pix_t o_b;

    logic [26:0] exp_q [$];     // {vsync, hsync, de, r, g, b}.
    longint      sum_r;
    longint      sum_g;
    longint      sum_b;
    int          gain_r;
    int          gain_g;
    int          gain_b;
    logic        last_vsync;
    logic        mon_en;
    int          de_driven;
    int          de_checked;

    wb_top UUT (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wb_en  (wb_en),
        .i_vsync  (vsync),
        .i_hsync  (hsync),
        .i_de     (de),
        .i_r      (r),
        .i_g      (g),
        .i_b      (b),
        .o_vsync  (o_vsync),
        .o_hsync  (o_hsync),
        .o_de     (o_de),
        .o_r      (o_r),
        .o_g      (o_g),
        .o_b      (o_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Gain = 256*T / (3*sum), unity for an empty channel.
    function automatic int gain_rule(input longint sum_c, input longint total);
        longint q;
        if (sum_c == 0)
            return GAIN_UNITY;
        q = (total * 256) / (3 * sum_c);
        return (q > GAIN_MAX) ? GAIN_MAX : int'(q);
    endfunction

    function automatic pix_t apply_gain(input pix_t p, input int gain);
        int v;
        v = (int'(p) * gain) / 256;
        return (v > 255) ? 8'hFF : pix_t'(v);
    endfunction

    task automatic pick_pixel(input int src, input pix_t cr, input pix_t cg, input pix_t cb,
                              output pix_t pr, output pix_t pg, output pix_t pb);
        pix_t level;
        level = pix_t'($urandom & 32'hFF);
        pr    = pix_t'($urandom & 32'hFF);
        pg    = pix_t'($urandom & 32'hFF);
        pb    = pix_t'($urandom & 32'hFF);
        case (src)
            SRC_GRAY: begin
                pr = level;
                pg = level;
                pb = level;
            end
            SRC_FIXED: begin
                pr = cr;
                pg = cg;
                pb = cb;
            end
            SRC_NO_BLUE: pb = 8'h00;
            default: ;
        endcase
    endtask

    // One clock of stimulus. The reference model follows the same cycle.
    task automatic drive_cycle(input logic vs, input logic hs, input logic en,
                               input pix_t pr, input pix_t pg, input pix_t pb);
        longint total;
        @(posedge clk);
        #1;
        vsync = vs;
        hsync = hs;
        de    = en;
        r     = pr;
        g     = pg;
        b     = pb;
        if (vs && !last_vsync) begin
            total = sum_r + sum_g + sum_b;
            if (wb_en) begin
                gain_r = gain_rule(sum_r, total);
                gain_g = gain_rule(sum_g, total);
                gain_b = gain_rule(sum_b, total);
            end
            sum_r = 0;
            sum_g = 0;
            sum_b = 0;
        end else if (en) begin
            sum_r     = sum_r + longint'(pr);
            sum_g     = sum_g + longint'(pg);
            sum_b     = sum_b + longint'(pb);
            de_driven = de_driven + 1;
        end
        last_vsync = vs;
        exp_q.push_back({vs, hs, en, apply_gain(pr, gain_r), apply_gain(pg, gain_g),
                         apply_gain(pb, gain_b)});
    endtask

    task automatic send_frame(input int src, input pix_t cr, input pix_t cg, input pix_t cb);
        pix_t pr;
        pix_t pg;
        pix_t pb;
        int   x;
        int   y;
        int   c;
        for (y = 0; y < FRAME_H; y++) begin
            for (c = 0; c < HSYNC_LEN; c++)
                drive_cycle(1'b0, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00);
            for (c = 0; c < H_PORCH; c++)
                drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
            for (x = 0; x < FRAME_W; x++) begin
                pick_pixel(src, cr, cg, cb, pr, pg, pb);
                drive_cycle(1'b0, 1'b0, 1'b1, pr, pg, pb);
            end
            for (c = 0; c < H_PORCH; c++)
                drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
        end
        for (c = 0; c < V_PRE; c++)
            drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
        for (c = 0; c < VSYNC_LEN; c++)
            drive_cycle(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
        for (c = 0; c < V_BLANK; c++)
            drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
    endtask

    // Outputs settle after the rising edge, so compare on the falling one.
    always @(negedge clk) begin
        logic [26:0] entry;
        if (mon_en && (exp_q.size() > PIPE_DEPTH)) begin
            entry = exp_q.pop_front();
            check_value("o_vsync", 64'(o_vsync), 64'(entry[26]));
            check_value("o_hsync", 64'(o_hsync), 64'(entry[25]));
            check_value("o_de", 64'(o_de), 64'(entry[24]));
            check_value("o_r", 64'(o_r), 64'(entry[23:16]));
            check_value("o_g", 64'(o_g), 64'(entry[15:8]));
            check_value("o_b", 64'(o_b), 64'(entry[7:0]));
            if (o_de)
                de_checked = de_checked + 1;
        end
    end

    task automatic test_reset_passthrough();
        send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);   // Unity gains since reset.
    endtask

    task automatic test_gray_unity();
        send_frame(SRC_GRAY, 8'h00, 8'h00, 8'h00);
        send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic test_colour_cast();
        send_frame(SRC_FIXED, 8'd100, 8'd150, 8'd200);
        send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);   // Red gain 1.5 clips.
    endtask

    task automatic test_zero_and_saturation();
        send_frame(SRC_NO_BLUE, 8'h00, 8'h00, 8'h00);
        send_frame(SRC_FIXED, 8'd1, 8'd200, 8'd200);
        send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic test_wb_disabled();
        wb_en = 1'b0;
        send_frame(SRC_FIXED, 8'd60, 8'd200, 8'd120);
        wb_en = 1'b1;
        send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic test_random_frames();
        int n;
        for (n = 0; n < 3; n++)
            send_frame(SRC_RANDOM, 8'h00, 8'h00, 8'h00);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        void'($urandom(26028));
        i_arst_n   = 1'b0;
        wb_en      = 1'b1;
        vsync      = 1'b0;
        hsync      = 1'b0;
        de         = 1'b0;
        r          = 8'h00;
        g          = 8'h00;
        b          = 8'h00;
        sum_r      = 0;
        sum_g      = 0;
        sum_b      = 0;
        gain_r     = GAIN_UNITY;
        gain_g     = GAIN_UNITY;
        gain_b     = GAIN_UNITY;
        last_vsync = 1'b0;
        mon_en     = 1'b0;
        de_driven  = 0;
        de_checked = 0;
        repeat (3) @(posedge clk);
        #1;
        i_arst_n = 1'b1;
        mon_en   = 1'b1;
        test_reset_passthrough();
        test_gray_unity();
        test_colour_cast();
        test_zero_and_saturation();
        test_wb_disabled();
        test_random_frames();
        check_value("de pixels compared", 64'(de_checked), 64'(de_driven));
        $display("All tests passed!");
        $finish;
    end

endmodule : wb_tb

`default_nettype wire

//--- verilog/stats_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stats_if import wb_pkg::*; ();

    sum_t sum_r;
    sum_t sum_g;
    sum_t sum_b;
    logic valid;    // One-cycle strobe per frame.

    modport src (
        output sum_r, sum_g, sum_b,
        output valid
    );

    modport sink (
        input  sum_r, sum_g, sum_b,
        input  valid
    );

endinterface : stats_if

`default_nettype wire

//--- verilog/video_if.sv
`timescale 1ns/10ps
`default_nettype none

interface video_if import wb_pkg::*; ();

    logic vsync;
    logic hsync;
    logic de;       // Pixel valid, no back-pressure.
    pix_t r;
    pix_t g;
    pix_t b;

    modport src (
        output vsync, hsync, de,
        output r, g, b
    );

    modport sink (
        input  vsync, hsync, de,
        input  r, g, b
    );

endinterface : video_if

`default_nettype wire

//--- verilog/wb_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module wb_ctrl import wb_pkg::*; (
    input  logic   clk,
    input  logic   i_arst_n,
    input  logic   i_wb_en,
    stats_if.sink  stats,
    output logic   o_div_start,
    output div_t   o_dividend,
    output div_t   o_divisor,
    input  div_t   i_quotient,
    input  logic   i_div_done,
    output gain_t  o_gain_r,
    output gain_t  o_gain_g,
    output gain_t  o_gain_b
);

    ctrl_state_t state;
    logic        started;   // Division issued for this channel.
    logic        in_div;
    logic        take;
    logic        issue;
    logic        finish;
    sum_t        sum_sel;
    sum_t        sum_r_q;
    sum_t        sum_g_q;
    sum_t        sum_b_q;
    gain_t       gain_next;
    gain_t       shadow_r;
    gain_t       shadow_g;
    gain_t       shadow_b;

    function automatic gain_t sat_gain(input div_t q);
        return (q > div_t'(GAIN_MAX)) ? gain_t'(GAIN_MAX) : q[GAIN_W-1:0];
    endfunction

    always_comb begin
        case (state)
            DIV_G:   sum_sel = sum_g_q;
            DIV_B:   sum_sel = sum_b_q;
            default: sum_sel = sum_r_q;
        endcase
    end

    assign in_div    = (state == DIV_R) || (state == DIV_G) || (state == DIV_B);
    assign take      = (state == IDLE) && stats.valid && i_wb_en;
    assign issue     = in_div && !started && (sum_sel != '0);
    // A zero sum finishes at once with unity gain.
    assign finish    = in_div && (started ? i_div_done : (sum_sel == '0));
    assign gain_next = started ? sat_gain(i_quotient) : gain_t'(GAIN_UNITY);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= IDLE;
            started     <= 1'b0;
            o_div_start <= 1'b0;
            o_gain_r    <= gain_t'(GAIN_UNITY);
            o_gain_g    <= gain_t'(GAIN_UNITY);
            o_gain_b    <= gain_t'(GAIN_UNITY);
        end else begin
            o_div_start <= issue;
            if (issue)
                started <= 1'b1;
            else if (finish)
                started <= 1'b0;
            case (state)
                IDLE:    if (take) state <= DIV_R;
                DIV_R:   if (finish) state <= DIV_G;
                DIV_G:   if (finish) state <= DIV_B;
                DIV_B:   if (finish) state <= COMMIT;
                COMMIT: begin
                    o_gain_r <= shadow_r;   // All three at once.
                    o_gain_g <= shadow_g;
                    o_gain_b <= shadow_b;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sum_r_q    <= stats.sum_r;
            sum_g_q    <= stats.sum_g;
            sum_b_q    <= stats.sum_b;
            o_dividend <= (div_t'(stats.sum_r) + div_t'(stats.sum_g) + div_t'(stats.sum_b))
                          << GAIN_FRAC;
        end
        if (issue)
            o_divisor <= div_t'(sum_sel) + (div_t'(sum_sel) << 1);  // 3 times the sum.
        if (finish) begin
            case (state)
                DIV_R:   shadow_r <= gain_next;
                DIV_G:   shadow_g <= gain_next;
                default: shadow_b <= gain_next;
            endcase
        end
    end

    // The channel with the largest sum never needs a boost.
    a_gain_set: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (state == COMMIT) |->
            ((shadow_r <= gain_t'(GAIN_UNITY)) || (shadow_g <= gain_t'(GAIN_UNITY))
             || (shadow_b <= gain_t'(GAIN_UNITY)))
    ) else $error("no gain at or below unity in the committed set");

endmodule : wb_ctrl

`default_nettype wire

//--- verilog/wb_divider.sv
`timescale 1ns/10ps
`default_nettype none

module wb_divider import wb_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_start,
    input  div_t i_dividend,
    input  div_t i_divisor,
    output div_t o_quotient,
    output logic o_done
);

    logic           busy;
    div_cnt_t       count;      // Quotient bits still to produce.
    div_t           rem;
    div_t           dvs;
    logic [DIV_W:0] partial;
    logic [DIV_W:0] diff;

    // Next dividend bit enters the remainder from the top of the quotient register.
    assign partial = {rem, o_quotient[DIV_W-1]};
    assign diff    = partial - {1'b0, dvs};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy   <= 1'b0;
            count  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy  <= 1'b1;
                count <= DIV_STEPS;
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == div_cnt_t'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            rem        <= '0;
            dvs        <= i_divisor;
            o_quotient <= i_dividend;
        end else if (busy) begin
            if (diff[DIV_W]) begin  // Went negative, restore.
                rem        <= partial[DIV_W-1:0];
                o_quotient <= {o_quotient[DIV_W-2:0], 1'b0};
            end else begin
                rem        <= diff[DIV_W-1:0];
                o_quotient <= {o_quotient[DIV_W-2:0], 1'b1};
            end
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_start |-> !busy
    ) else $error("divider started while busy");

endmodule : wb_divider

`default_nettype wire

//--- verilog/wb_pixel_gain.sv
`timescale 1ns/10ps
`default_nettype none

module wb_pixel_gain import wb_pkg::*; (
    input  logic   clk,
    input  logic   i_arst_n,
    video_if.sink  vin,
    video_if.src   vout,
    input  gain_t  i_gain_r,
    input  gain_t  i_gain_g,
    input  gain_t  i_gain_b
);

    prod_t prod_r;
    prod_t prod_g;
    prod_t prod_b;
    logic  vsync_1;
    logic  hsync_1;
    logic  de_1;

    // Drop the fraction and clip to full scale.
    function automatic pix_t clip(input prod_t p);
        logic [PIX_W+GAIN_W-GAIN_FRAC-1:0] s;
        s = p[PIX_W+GAIN_W-1:GAIN_FRAC];
        return (|s[PIX_W+GAIN_W-GAIN_FRAC-1:PIX_W]) ? '1 : s[PIX_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            prod_r     <= '0;
            prod_g     <= '0;
            prod_b     <= '0;
            vsync_1    <= 1'b0;
            hsync_1    <= 1'b0;
            de_1       <= 1'b0;
            vout.r     <= '0;
            vout.g     <= '0;
            vout.b     <= '0;
            vout.vsync <= 1'b0;
            vout.hsync <= 1'b0;
            vout.de    <= 1'b0;
        end else begin
            // Stage 1.
            prod_r     <= vin.r * i_gain_r;
            prod_g     <= vin.g * i_gain_g;
            prod_b     <= vin.b * i_gain_b;
            vsync_1    <= vin.vsync;
            hsync_1    <= vin.hsync;
            de_1       <= vin.de;
            // Stage 2.
            vout.r     <= clip(prod_r);
            vout.g     <= clip(prod_g);
            vout.b     <= clip(prod_b);
            vout.vsync <= vsync_1;
            vout.hsync <= hsync_1;
            vout.de    <= de_1;
        end
    end

    // Unity gains pass a pixel through unchanged.
    a_unity_pass: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        ($past({i_gain_r, i_gain_g, i_gain_b}, 2) == {3{gain_t'(GAIN_UNITY)}})
            |-> ({vout.r, vout.g, vout.b} == $past({vin.r, vin.g, vin.b}, 2))
    ) else $error("unity gain changed a pixel");

endmodule : wb_pixel_gain

`default_nettype wire

//--- verilog/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Nominal active frame. It only sizes the accumulators.
    localparam int H_ACT      = 1280;
    localparam int V_ACT      = 720;

    localparam int PIX_W      = 8;
    localparam int SUM_W      = $clog2(H_ACT * V_ACT * ((1 << PIX_W) - 1));
    localparam int GAIN_FRAC  = 8;
    localparam int GAIN_W     = 10;                 // Range 0 to 1023/256.
    localparam int GAIN_UNITY = 1 << GAIN_FRAC;
    localparam int GAIN_MAX   = (1 << GAIN_W) - 1;

    // Three sums need two more bits, then the fraction shift.
    localparam int DIV_W      = SUM_W + 2 + GAIN_FRAC;
    localparam int DIV_CNT_W  = $clog2(DIV_W + 1);

    typedef logic [PIX_W-1:0]          pix_t;
    typedef logic [SUM_W-1:0]          sum_t;
    typedef logic [GAIN_W-1:0]         gain_t;
    typedef logic [DIV_W-1:0]          div_t;
    typedef logic [PIX_W+GAIN_W-1:0]   prod_t;      // Pixel times gain, before the shift.
    typedef logic [DIV_CNT_W-1:0]      div_cnt_t;

    localparam div_cnt_t DIV_STEPS = div_cnt_t'(DIV_W);

    typedef enum logic [2:0] {
        IDLE,
        DIV_R,
        DIV_G,
        DIV_B,
        COMMIT
    } ctrl_state_t;

endpackage : wb_pkg

`default_nettype wire

//--- verilog/wb_stats_accum.sv
`timescale 1ns/10ps
`default_nettype none

module wb_stats_accum import wb_pkg::*; (
    input  logic   clk,
    input  logic   i_arst_n,
    video_if.sink  vid,
    stats_if.src   stats
);

    logic vsync_d;
    logic vsync_rise;
    sum_t run_r;
    sum_t run_g;
    sum_t run_b;

    assign vsync_rise = vid.vsync & ~vsync_d;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vsync_d     <= 1'b0;
            stats.valid <= 1'b0;
            stats.sum_r <= '0;
            stats.sum_g <= '0;
            stats.sum_b <= '0;
            run_r       <= '0;
            run_g       <= '0;
            run_b       <= '0;
        end else begin
            vsync_d     <= vid.vsync;
            stats.valid <= vsync_rise;
            // Frame boundary. Snapshot the totals and start over.
            if (vsync_rise) begin
                stats.sum_r <= run_r;
                stats.sum_g <= run_g;
                stats.sum_b <= run_b;
                run_r       <= '0;
                run_g       <= '0;
                run_b       <= '0;
            end else if (vid.de) begin
                run_r <= run_r + sum_t'(vid.r);
                run_g <= run_g + sum_t'(vid.g);
                run_b <= run_b + sum_t'(vid.b);
            end
        end
    end

    // A pixel during vsync would be lost to the snapshot.
    a_no_de_in_vsync: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(vid.de && vid.vsync)
    ) else $error("de high while vsync is high");

endmodule : wb_stats_accum

`default_nettype wire

//--- verilog/wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_top import wb_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_wb_en,
    input  logic i_vsync,
    input  logic i_hsync,
    input  logic i_de,
    input  pix_t i_r,
    input  pix_t i_g,
    input  pix_t i_b,
    output logic o_vsync,
    output logic o_hsync,
    output logic o_de,
    output pix_t o_r,
    output pix_t o_g,
    output pix_t o_b
);

    video_if vid_in ();
    video_if vid_out ();
    stats_if stats ();

    logic  div_start;
    div_t  dividend;
    div_t  divisor;
    div_t  quotient;
    logic  div_done;
    gain_t gain_r;
    gain_t gain_g;
    gain_t gain_b;

    assign vid_in.vsync = i_vsync;
    assign vid_in.hsync = i_hsync;
    assign vid_in.de    = i_de;
    assign vid_in.r     = i_r;
    assign vid_in.g     = i_g;
    assign vid_in.b     = i_b;

    assign o_vsync = vid_out.vsync;
    assign o_hsync = vid_out.hsync;
    assign o_de    = vid_out.de;
    assign o_r     = vid_out.r;
    assign o_g     = vid_out.g;
    assign o_b     = vid_out.b;

    wb_stats_accum u_accum (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .vid      (vid_in.sink),
        .stats    (stats.src)
    );

    wb_ctrl u_ctrl (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_wb_en     (i_wb_en),
        .stats       (stats.sink),
        .o_div_start (div_start),
        .o_dividend  (dividend),
        .o_divisor   (divisor),
        .i_quotient  (quotient),
        .i_div_done  (div_done),
        .o_gain_r    (gain_r),
        .o_gain_g    (gain_g),
        .o_gain_b    (gain_b)
    );

    wb_divider u_div (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (div_start),
        .i_dividend (dividend),
        .i_divisor  (divisor),
        .o_quotient (quotient),
        .o_done     (div_done)
    );

    wb_pixel_gain u_gain (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .vin      (vid_in.sink),
        .vout     (vid_out.src),
        .i_gain_r (gain_r),
        .i_gain_g (gain_g),
        .i_gain_b (gain_b)
    );

endmodule : wb_top

`default_nettype wire
